// File: include/vga_regs_params.svh
`ifndef VGA_REGS_PARAMS_SVH
`define VGA_REGS_PARAMS_SVH

// register word offsets, taken from address bits 5:2
`define VGA_REG_CONTROL     4'h0
`define VGA_REG_STATUS      4'h1
`define VGA_REG_INT_FLAGS   4'h2
`define VGA_REG_INT_SELECT  4'h3
`define VGA_REG_BUF_ADDR    4'h4
`define VGA_REG_BPR         4'h5
`define VGA_REG_STEP        4'h6
`define VGA_REG_VDISP       4'hC

// configuration values after reset
`define VGA_BPR_DEFAULT     1920
`define VGA_STEP_DEFAULT    1920
// number of rows minus one
`define VGA_VDISP_DEFAULT   479

// one hold phase is 2**VGA_HOLD_BITS cycles
`define VGA_HOLD_BITS       4

// interrupt flag bit positions
`define VGA_INT_FRAME_START 0
`define VGA_INT_FRAME_DONE  1
`define VGA_INT_UNDERRUN    2
`define VGA_INT_PX_RST      3
`define VGA_INT_AXI_ERROR   4

`endif

// File: logic/vga_regs_pkg.sv
`default_nettype none

`include "vga_regs_params.svh"

package vga_regs_pkg;

    typedef logic [31:0] csr_word_t;
    typedef logic [3:0]  csr_idx_t;
    typedef logic [31:0] bus_addr_t;
    typedef logic [11:0] row_bytes_t;
    typedef logic [11:0] row_idx_t;
    // one bit per interrupt source
    typedef logic [`VGA_INT_AXI_ERROR:0] int_vec_t;

    typedef enum logic [2:0] {
        st_rst,
        st_halt,
        st_init,
        st_start,
        st_wait,
        st_ur_halt,
        st_ur_rst,
        st_ur_init
    } frame_state_t;

    // one decoded APB setup-phase access
    typedef struct packed {
        logic       rd;
        logic       wr;
        csr_idx_t   idx;
        csr_word_t  wdata;
        logic [3:0] strb;
    } csr_access_t;

    typedef struct packed {
        bus_addr_t  buf_addr;
        row_bytes_t bytes_per_row;
        bus_addr_t  row_step;
        row_idx_t   vdisp;
    } frame_cfg_t;

    // field order matches the int_vec_t bit positions
    typedef struct packed {
        logic axi_error;
        logic px_rst;
        logic underrun;
        logic frame_done;
        logic frame_start;
    } px_events_t;

    typedef struct packed {
        bus_addr_t  addr;
        row_bytes_t bytes;
    } read_cmd_t;

endpackage

`default_nettype wire

// File: logic/vga_csr_file.sv
`default_nettype none

`include "vga_regs_params.svh"

module vga_csr_file (
    input  wire logic                    clk,
    input  wire logic                    rst_in,
    input  wire vga_regs_pkg::bus_addr_t apb_addr,
    input  wire logic                    apb_sel,
    input  wire logic                    apb_enable,
    input  wire logic                    apb_write,
    input  wire vga_regs_pkg::csr_word_t apb_wdata,
    input  wire logic [3:0]              apb_strb,
    input  wire vga_regs_pkg::int_vec_t  int_flags,
    input  wire vga_regs_pkg::int_vec_t  int_select,
    input  wire logic                    px_rst,
    input  wire logic                    axi_busy,
    output logic                         apb_ready,
    output vga_regs_pkg::csr_word_t      apb_rdata,
    output vga_regs_pkg::csr_access_t    csr_acc,
    output logic                         ctrl_enable,
    output vga_regs_pkg::frame_cfg_t     frame_cfg
);

    vga_regs_pkg::csr_word_t wmask;

    function automatic vga_regs_pkg::csr_word_t merge(
        input vga_regs_pkg::csr_word_t cur,
        input vga_regs_pkg::csr_word_t mask,
        input vga_regs_pkg::csr_word_t data
    );
        return (cur & ~mask) | (data & mask);
    endfunction

    // accesses are taken in the setup cycle only
    assign csr_acc = '{
        rd:    apb_sel && !apb_enable && !apb_write,
        wr:    apb_sel && !apb_enable && apb_write,
        idx:   apb_addr[5:2],
        wdata: apb_wdata,
        strb:  apb_strb
    };

    // per-bit write enable from the byte strobes
    assign wmask = {32{csr_acc.wr}} & {{8{csr_acc.strb[3]}}, {8{csr_acc.strb[2]}},
                                       {8{csr_acc.strb[1]}}, {8{csr_acc.strb[0]}}};

    always_ff @(posedge clk) begin
        if (rst_in) begin
            ctrl_enable <= 1'b0;
        end else if (ctrl_enable && px_rst) begin
            // pixel side went into reset, drop out of the running state
            ctrl_enable <= 1'b0;
        end else if (csr_acc.idx == `VGA_REG_CONTROL && wmask[0]) begin
            ctrl_enable <= csr_acc.wdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_in) begin
            frame_cfg.buf_addr      <= '0;
            frame_cfg.bytes_per_row <= vga_regs_pkg::row_bytes_t'(`VGA_BPR_DEFAULT);
            frame_cfg.row_step      <= vga_regs_pkg::bus_addr_t'(`VGA_STEP_DEFAULT);
            frame_cfg.vdisp         <= vga_regs_pkg::row_idx_t'(`VGA_VDISP_DEFAULT);
        end else begin
            // buffer address may change between frames
            if (csr_acc.idx == `VGA_REG_BUF_ADDR) begin
                frame_cfg.buf_addr <= merge(frame_cfg.buf_addr, wmask, csr_acc.wdata);
            end
            // geometry only changes while stopped
            if (!ctrl_enable) begin
                case (csr_acc.idx)
                    `VGA_REG_BPR: begin
                        frame_cfg.bytes_per_row <= vga_regs_pkg::row_bytes_t'(merge(
                            vga_regs_pkg::csr_word_t'(frame_cfg.bytes_per_row),
                            wmask, csr_acc.wdata));
                    end
                    `VGA_REG_STEP: begin
                        frame_cfg.row_step <= merge(frame_cfg.row_step, wmask, csr_acc.wdata);
                    end
                    `VGA_REG_VDISP: begin
                        frame_cfg.vdisp <= vga_regs_pkg::row_idx_t'(merge(
                            vga_regs_pkg::csr_word_t'(frame_cfg.vdisp),
                            wmask, csr_acc.wdata));
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_in) begin
            apb_ready <= 1'b0;
        end else begin
            apb_ready <= apb_sel && !apb_enable;
        end
    end

    // read data lands together with ready
    always_ff @(posedge clk) begin
        apb_rdata <= '0;
        if (csr_acc.rd) begin
            case (csr_acc.idx)
                `VGA_REG_CONTROL:    apb_rdata <= {31'd0, ctrl_enable};
                `VGA_REG_STATUS:     apb_rdata <= {14'd0, axi_busy, px_rst, 16'd0};
                `VGA_REG_INT_FLAGS:  apb_rdata <= vga_regs_pkg::csr_word_t'(int_flags);
                `VGA_REG_INT_SELECT: apb_rdata <= vga_regs_pkg::csr_word_t'(int_select);
                `VGA_REG_BUF_ADDR:   apb_rdata <= frame_cfg.buf_addr;
                `VGA_REG_BPR:
                    apb_rdata <= vga_regs_pkg::csr_word_t'(frame_cfg.bytes_per_row);
                `VGA_REG_STEP:       apb_rdata <= frame_cfg.row_step;
                `VGA_REG_VDISP:      apb_rdata <= vga_regs_pkg::csr_word_t'(frame_cfg.vdisp);
                default:             apb_rdata <= '0;
            endcase
        end
    end

    // each transfer gets exactly one ready cycle
    assert property (@(posedge clk) disable iff (rst_in) apb_ready |=> !apb_ready);

endmodule

`default_nettype wire

// File: logic/vga_irq_ctrl.sv
`default_nettype none

`include "vga_regs_params.svh"

module vga_irq_ctrl (
    input  wire logic                      clk,
    input  wire logic                      rst_in,
    input  wire vga_regs_pkg::csr_access_t csr_acc,
    input  wire vga_regs_pkg::px_events_t  events,
    output vga_regs_pkg::int_vec_t         int_flags,
    output vga_regs_pkg::int_vec_t         int_select,
    output logic                           int_out
);

    vga_regs_pkg::int_vec_t set_vec;
    vga_regs_pkg::int_vec_t clr_vec;
    logic                   low_byte_wr;

    // all flag bits live in byte 0
    assign low_byte_wr = csr_acc.wr && csr_acc.strb[0];

    always_comb begin
        set_vec = '0;
        set_vec[`VGA_INT_FRAME_START] = events.frame_start;
        set_vec[`VGA_INT_FRAME_DONE]  = events.frame_done;
        set_vec[`VGA_INT_UNDERRUN]    = events.underrun;
        set_vec[`VGA_INT_PX_RST]      = events.px_rst;
        set_vec[`VGA_INT_AXI_ERROR]   = events.axi_error;
    end

    assign clr_vec = (low_byte_wr && csr_acc.idx == `VGA_REG_INT_FLAGS) ?
                     csr_acc.wdata[`VGA_INT_AXI_ERROR:0] : '0;

    always_ff @(posedge clk) begin
        if (rst_in) begin
            int_flags  <= '0;
            int_select <= '0;
            int_out    <= 1'b0;
        end else begin
            // a new event beats a clear in the same cycle
            int_flags <= (int_flags & ~clr_vec) | set_vec;
            if (low_byte_wr && csr_acc.idx == `VGA_REG_INT_SELECT) begin
                int_select <= csr_acc.wdata[`VGA_INT_AXI_ERROR:0];
            end
            int_out <= |(int_flags & int_select);
        end
    end

endmodule

`default_nettype wire

// File: logic/vga_frame_fsm.sv
`default_nettype none

`include "vga_regs_params.svh"

module vga_frame_fsm (
    input  wire logic                     clk,
    input  wire logic                     rst_in,
    input  wire logic                     ctrl_enable,
    input  wire vga_regs_pkg::px_events_t events,
    input  wire logic                     axi_busy,
    output logic                          start_frame,
    output logic                          axi_halt,
    output logic                          rst_bus,
    output logic                          rst_drv
);

    vga_regs_pkg::frame_state_t state;
    vga_regs_pkg::frame_state_t next_state;
    logic [`VGA_HOLD_BITS-1:0]  hold_cnt;
    logic                       hold_clr;
    logic                       hold_done;

    assign hold_done   = &hold_cnt;
    assign start_frame = (state == vga_regs_pkg::st_start);

    always_comb begin
        next_state = state;
        hold_clr   = 1'b1;
        case (state)
            // wait out a phase and for the reader to go idle
            vga_regs_pkg::st_halt, vga_regs_pkg::st_ur_halt: begin
                hold_clr = 1'b0;
                if (hold_done && !axi_busy) begin
                    next_state = (state == vga_regs_pkg::st_halt) ?
                                 vga_regs_pkg::st_rst : vga_regs_pkg::st_ur_rst;
                    hold_clr   = 1'b1;
                end
            end
            vga_regs_pkg::st_rst: begin
                if (ctrl_enable) begin
                    hold_clr = 1'b0;
                    if (hold_done) begin
                        next_state = vga_regs_pkg::st_init;
                        hold_clr   = 1'b1;
                    end
                end
            end
            // plain timed phases
            vga_regs_pkg::st_init, vga_regs_pkg::st_ur_rst, vga_regs_pkg::st_ur_init: begin
                hold_clr = 1'b0;
                if (hold_done) begin
                    hold_clr = 1'b1;
                    if (state == vga_regs_pkg::st_init) begin
                        next_state = vga_regs_pkg::st_start;
                    end else if (state == vga_regs_pkg::st_ur_rst) begin
                        next_state = vga_regs_pkg::st_ur_init;
                    end else begin
                        // resume on the next frame boundary
                        next_state = vga_regs_pkg::st_wait;
                    end
                end
            end
            vga_regs_pkg::st_start: next_state = vga_regs_pkg::st_wait;
            vga_regs_pkg::st_wait: begin
                if (events.frame_done) begin
                    next_state = vga_regs_pkg::st_start;
                end
            end
            default: next_state = vga_regs_pkg::st_rst;
        endcase

        if (ctrl_enable && (events.underrun || events.axi_error) &&
            state != vga_regs_pkg::st_ur_halt && state != vga_regs_pkg::st_ur_rst) begin
            next_state = vga_regs_pkg::st_ur_halt;
            hold_clr   = 1'b1;
        end

        // disable overrides everything
        if (!ctrl_enable && state != vga_regs_pkg::st_halt && state != vga_regs_pkg::st_rst) begin
            next_state = vga_regs_pkg::st_halt;
            hold_clr   = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_in || hold_clr) begin
            hold_cnt <= '0;
        end else begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_in) begin
            state    <= vga_regs_pkg::st_rst;
            axi_halt <= 1'b1;
            rst_bus  <= 1'b1;
            rst_drv  <= 1'b1;
        end else begin
            state    <= next_state;
            // output driver goes down as soon as we disable
            rst_drv  <= next_state inside {vga_regs_pkg::st_rst, vga_regs_pkg::st_halt};
            // bus side only once the reader has stopped
            rst_bus  <= next_state inside {vga_regs_pkg::st_rst, vga_regs_pkg::st_ur_rst};
            axi_halt <= next_state inside {vga_regs_pkg::st_rst, vga_regs_pkg::st_halt,
                                           vga_regs_pkg::st_ur_rst, vga_regs_pkg::st_ur_halt};
        end
    end

    // the reader is halted a cycle ahead of its reset and all through it
    assert property (@(posedge clk) disable iff (rst_in)
        rst_bus |-> axi_halt && $past(axi_halt));

endmodule

`default_nettype wire

// File: logic/vga_row_cmd_gen.sv
`default_nettype none

`include "vga_regs_params.svh"

module vga_row_cmd_gen (
    input  wire logic                     clk,
    input  wire logic                     rst_bus,
    input  wire logic                     start_frame,
    input  wire vga_regs_pkg::frame_cfg_t frame_cfg,
    input  wire logic                     axi_cmd_ready,
    output vga_regs_pkg::read_cmd_t       axi_cmd,
    output logic                          axi_cmd_valid
);

    vga_regs_pkg::row_idx_t  row;
    vga_regs_pkg::bus_addr_t cmd_addr;
    logic                    row_last;
    logic                    advance;

    assign row_last = (row == '0);
    // next row goes out once the previous command has been taken
    assign advance  = !axi_cmd_valid && !row_last;

    always_ff @(posedge clk) begin
        if (rst_bus) begin
            axi_cmd_valid <= 1'b0;
            row           <= '0;
        end else if (start_frame) begin
            axi_cmd_valid <= 1'b1;
            row           <= frame_cfg.vdisp;
        end else if (advance) begin
            axi_cmd_valid <= 1'b1;
            row           <= row - 1'b1;
        end else if (axi_cmd_valid && axi_cmd_ready) begin
            axi_cmd_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_frame) begin
            cmd_addr <= frame_cfg.buf_addr;
        end else if (advance) begin
            cmd_addr <= cmd_addr + frame_cfg.row_step;
        end
    end

    assign axi_cmd = '{addr: cmd_addr, bytes: frame_cfg.bytes_per_row};

    // command held under back-pressure
    assert property (@(posedge clk) disable iff (rst_bus)
        axi_cmd_valid && !axi_cmd_ready |=> axi_cmd_valid && $stable(axi_cmd));

    // FSM restarts only after the last row of the previous frame went out
    assert property (@(posedge clk) disable iff (rst_bus)
        start_frame |-> !axi_cmd_valid && row_last);

endmodule

`default_nettype wire

// File: logic/vga_regs_top.sv
`default_nettype none

`include "vga_regs_params.svh"

module vga_regs_top (
    input  wire logic                    clk,
    input  wire logic                    rst_in,
    input  wire vga_regs_pkg::bus_addr_t apb_addr,
    input  wire logic                    apb_sel,
    input  wire logic                    apb_enable,
    input  wire logic                    apb_write,
    input  wire vga_regs_pkg::csr_word_t apb_wdata,
    input  wire logic [3:0]              apb_strb,
    input  wire logic                    px_frame_start,
    input  wire logic                    px_frame_done,
    input  wire logic                    px_underrun,
    input  wire logic                    px_rst,
    input  wire logic                    axi_busy,
    input  wire logic                    axi_error,
    input  wire logic                    axi_cmd_ready,
    output logic                         apb_ready,
    output vga_regs_pkg::csr_word_t      apb_rdata,
    output logic                         int_out,
    output logic                         axi_halt,
    output logic                         rst_bus,
    output logic                         rst_drv,
    output vga_regs_pkg::read_cmd_t      axi_cmd,
    output logic                         axi_cmd_valid
);

    vga_regs_pkg::csr_access_t csr_acc;
    vga_regs_pkg::int_vec_t    int_flags;
    vga_regs_pkg::int_vec_t    int_select;
    vga_regs_pkg::frame_cfg_t  frame_cfg;
    vga_regs_pkg::px_events_t  events;
    logic                      ctrl_enable;
    logic                      start_frame;

    // status inputs already arrive in the clk domain
    assign events = '{
        axi_error:   axi_error,
        px_rst:      px_rst,
        underrun:    px_underrun,
        frame_done:  px_frame_done,
        frame_start: px_frame_start
    };

    vga_csr_file u_csr_file (
        .clk         (clk),
        .rst_in      (rst_in),
        .apb_addr    (apb_addr),
        .apb_sel     (apb_sel),
        .apb_enable  (apb_enable),
        .apb_write   (apb_write),
        .apb_wdata   (apb_wdata),
        .apb_strb    (apb_strb),
        .int_flags   (int_flags),
        .int_select  (int_select),
        .px_rst      (px_rst),
        .axi_busy    (axi_busy),
        .apb_ready   (apb_ready),
        .apb_rdata   (apb_rdata),
        .csr_acc     (csr_acc),
        .ctrl_enable (ctrl_enable),
        .frame_cfg   (frame_cfg)
    );

    vga_irq_ctrl u_irq_ctrl (
        .clk        (clk),
        .rst_in     (rst_in),
        .csr_acc    (csr_acc),
        .events     (events),
        .int_flags  (int_flags),
        .int_select (int_select),
        .int_out    (int_out)
    );

    vga_frame_fsm u_frame_fsm (
        .clk         (clk),
        .rst_in      (rst_in),
        .ctrl_enable (ctrl_enable),
        .events      (events),
        .axi_busy    (axi_busy),
        .start_frame (start_frame),
        .axi_halt    (axi_halt),
        .rst_bus     (rst_bus),
        .rst_drv     (rst_drv)
    );

    vga_row_cmd_gen u_row_cmd_gen (
        .clk           (clk),
        .rst_bus       (rst_bus),
        .start_frame   (start_frame),
        .frame_cfg     (frame_cfg),
        .axi_cmd_ready (axi_cmd_ready),
        .axi_cmd       (axi_cmd),
        .axi_cmd_valid (axi_cmd_valid)
    );

endmodule

`default_nettype wire

// File: tests/tb_vga_regs.sv
`default_nettype none

`include "vga_regs_params.svh"

module tb_vga_regs;

    logic                    clk;
    logic                    rst_in;
    vga_regs_pkg::bus_addr_t apb_addr;
    logic                    apb_sel;
    logic                    apb_enable;
    logic                    apb_write;
    vga_regs_pkg::csr_word_t apb_wdata;
    logic [3:0]              apb_strb;
    logic                    px_frame_start;
    logic                    px_frame_done;
    logic                    px_underrun;
    logic                    px_rst;
    logic                    axi_busy;
    logic                    axi_error;
    logic                    axi_cmd_ready;
    logic                    apb_ready;
    vga_regs_pkg::csr_word_t apb_rdata;
    logic                    int_out;
    logic                    axi_halt;
    logic                    rst_bus;
    logic                    rst_drv;
    vga_regs_pkg::read_cmd_t axi_cmd;
    logic                    axi_cmd_valid;

    // event inputs indexed by interrupt bit position
    logic [4:0]  event_drv;
    logic [31:0] rng;
    int          errors;
    int          errors_at_start;
    int          pass_count;
    int          fail_count;
    string       cur_test;

    assign px_frame_start = event_drv[`VGA_INT_FRAME_START];
    assign px_frame_done  = event_drv[`VGA_INT_FRAME_DONE];
    assign px_underrun    = event_drv[`VGA_INT_UNDERRUN];
    assign px_rst         = event_drv[`VGA_INT_PX_RST];
    assign axi_error      = event_drv[`VGA_INT_AXI_ERROR];

    vga_regs_top u_vga_regs_top (
        .clk            (clk),
        .rst_in         (rst_in),
        .apb_addr       (apb_addr),
        .apb_sel        (apb_sel),
        .apb_enable     (apb_enable),
        .apb_write      (apb_write),
        .apb_wdata      (apb_wdata),
        .apb_strb       (apb_strb),
        .px_frame_start (px_frame_start),
        .px_frame_done  (px_frame_done),
        .px_underrun    (px_underrun),
        .px_rst         (px_rst),
        .axi_busy       (axi_busy),
        .axi_error      (axi_error),
        .axi_cmd_ready  (axi_cmd_ready),
        .apb_ready      (apb_ready),
        .apb_rdata      (apb_rdata),
        .int_out        (int_out),
        .axi_halt       (axi_halt),
        .rst_bus        (rst_bus),
        .rst_drv        (rst_drv),
        .axi_cmd        (axi_cmd),
        .axi_cmd_valid  (axi_cmd_valid)
    );

    always #10 clk = ~clk;

    // an offered command waits unchanged for ready
    assert property (@(posedge clk) disable iff (rst_in || rst_bus)
        axi_cmd_valid && !axi_cmd_ready |=> axi_cmd_valid && $stable(axi_cmd))
    else begin
        $display("%s: command changed or dropped while waiting for ready", cur_test);
        errors++;
    end

    // reader reset flushes any pending command
    assert property (@(posedge clk) disable iff (rst_in) rst_bus |=> !axi_cmd_valid)
    else begin
        $display("%s: command still valid after reader reset", cur_test);
        errors++;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] apply_byte_strobe(input logic [31:0] old_val,
                                                      input logic [31:0] new_val,
                                                      input logic [3:0]  strb);
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic draw_rand(output logic [31:0] v);
        rng = xorshift32(rng);
        v = rng;
    endtask

    task automatic check_value(input string item, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR %s %s expected %h actual %h", cur_test, item, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("%s: %s", cur_test, msg);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        if (errors == errors_at_start) begin
            $display("test %s: ok", cur_test);
            pass_count++;
        end else begin
            $display("test %s: %0d error(s)", cur_test, errors - errors_at_start);
            fail_count++;
        end
    endtask

    // called 2 units after a rising edge, returns at the same phase
    task automatic apb_transfer(input logic wr, input logic [3:0] idx,
                                input logic [31:0] wdata, input logic [3:0] strb,
                                output logic [31:0] rdata);
        int waited;
        apb_addr   = {26'd0, idx, 2'b00};
        apb_sel    = 1'b1;
        apb_enable = 1'b0;
        apb_write  = wr;
        apb_wdata  = wdata;
        apb_strb   = strb;
        @(posedge clk);
        #2;
        apb_enable = 1'b1;
        while (!apb_ready && waited < 20) begin
            @(posedge clk);
            #2;
            waited++;
        end
        check_true(apb_ready, "timeout waiting for APB ready");
        rdata = apb_rdata;
        @(posedge clk);
        #2;
        apb_sel    = 1'b0;
        apb_enable = 1'b0;
        apb_write  = 1'b0;
    endtask

    task automatic apb_write_reg(input logic [3:0] idx, input logic [31:0] data,
                                 input logic [3:0] strb);
        logic [31:0] unused;
        apb_transfer(1'b1, idx, data, strb, unused);
    endtask

    task automatic apb_read_reg(input logic [3:0] idx, output logic [31:0] data);
        apb_transfer(1'b0, idx, 32'd0, 4'h0, data);
    endtask

    task automatic read_expect(input logic [3:0] idx, input logic [31:0] exp,
                               input string item);
        logic [31:0] data;
        apb_read_reg(idx, data);
        check_value(item, exp, data);
    endtask

    task automatic pulse_event(input int bit_pos);
        event_drv[bit_pos] = 1'b1;
        @(posedge clk);
        #2;
        event_drv[bit_pos] = 1'b0;
    endtask

    task automatic expect_no_command(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #2;
            check_true(!axi_cmd_valid, "unexpected read command");
        end
    endtask

    task automatic wait_halt_low(input int limit);
        int waited;
        while (axi_halt && waited < limit) begin
            check_true(!axi_cmd_valid, "read command during underrun recovery");
            @(posedge clk);
            #2;
            waited++;
        end
        check_true(!axi_halt, "timeout waiting for axi_halt to fall");
    endtask

    task automatic wait_bus_reset(input int limit);
        int waited;
        while (!rst_bus && waited < limit) begin
            @(posedge clk);
            #2;
            waited++;
        end
        check_true(rst_bus, "timeout waiting for rst_bus to rise");
    endtask

    // random ready, one transfer checked per accepted row
    task automatic collect_rows(input int n, input logic [31:0] base,
                                input logic [31:0] step, input logic [11:0] bytes);
        int          got;
        int          waited;
        logic [31:0] r;
        while (got < n && waited < 400) begin
            draw_rand(r);
            axi_cmd_ready = r[0];
            if (axi_cmd_valid && axi_cmd_ready) begin
                check_value("row address", base + 32'(got) * step, axi_cmd.addr);
                check_value("row bytes", {20'd0, bytes}, {20'd0, axi_cmd.bytes});
                got++;
            end
            @(posedge clk);
            #2;
            waited++;
        end
        axi_cmd_ready = 1'b1;
        check_true(got == n, "timeout waiting for row commands");
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0]  strb;
        logic [11:0] bpr;
        logic [31:0] step;
        logic [11:0] vd;
        logic [31:0] base;
        logic [4:0]  exp_flags;
        logic [4:0]  sel;
        logic [4:0]  clr;

        clk           = 1'b0;
        rst_in        = 1'b1;
        apb_addr      = '0;
        apb_sel       = 1'b0;
        apb_enable    = 1'b0;
        apb_write     = 1'b0;
        apb_wdata     = '0;
        apb_strb      = '0;
        event_drv     = '0;
        axi_busy      = 1'b0;
        axi_cmd_ready = 1'b1;
        rng           = 32'h395c;
        errors        = 0;
        pass_count    = 0;
        fail_count    = 0;
        cur_test      = "reset";
        repeat (8) @(posedge clk);
        #2;
        rst_in = 1'b0;

        start_test("reset_defaults");
        check_value("axi_halt", 1, {31'd0, axi_halt});
        check_value("rst_bus", 1, {31'd0, rst_bus});
        check_value("rst_drv", 1, {31'd0, rst_drv});
        check_value("int_out", 0, {31'd0, int_out});
        check_value("axi_cmd_valid", 0, {31'd0, axi_cmd_valid});
        read_expect(`VGA_REG_CONTROL, 32'd0, "control");
        read_expect(`VGA_REG_STATUS, 32'd0, "status");
        read_expect(`VGA_REG_INT_FLAGS, 32'd0, "int flags");
        read_expect(`VGA_REG_INT_SELECT, 32'd0, "int select");
        read_expect(`VGA_REG_BUF_ADDR, 32'd0, "buf addr");
        read_expect(`VGA_REG_BPR, `VGA_BPR_DEFAULT, "bytes per row");
        read_expect(`VGA_REG_STEP, `VGA_STEP_DEFAULT, "row step");
        read_expect(`VGA_REG_VDISP, `VGA_VDISP_DEFAULT, "vdisp");
        read_expect(4'h8, 32'd0, "unused offset");
        finish_test();

        start_test("byte_strobes");
        draw_rand(a);
        draw_rand(b);
        draw_rand(r);
        strb = r[3:0];
        apb_write_reg(`VGA_REG_BUF_ADDR, a, 4'hf);
        apb_write_reg(`VGA_REG_BUF_ADDR, b, strb);
        read_expect(`VGA_REG_BUF_ADDR, apply_byte_strobe(a, b, strb), "buf addr");
        draw_rand(r);
        bpr = r[11:0];
        vd  = r[27:16];
        draw_rand(step);
        // geometry locked while running
        apb_write_reg(`VGA_REG_CONTROL, 32'd1, 4'hf);
        apb_write_reg(`VGA_REG_BPR, {20'd0, bpr}, 4'hf);
        apb_write_reg(`VGA_REG_STEP, step, 4'hf);
        apb_write_reg(`VGA_REG_VDISP, {20'd0, vd}, 4'hf);
        read_expect(`VGA_REG_BPR, `VGA_BPR_DEFAULT, "locked bytes per row");
        apb_write_reg(`VGA_REG_CONTROL, 32'd0, 4'hf);
        read_expect(`VGA_REG_STEP, `VGA_STEP_DEFAULT, "locked row step");
        read_expect(`VGA_REG_VDISP, `VGA_VDISP_DEFAULT, "locked vdisp");
        apb_write_reg(`VGA_REG_BPR, {20'd0, bpr}, 4'hf);
        apb_write_reg(`VGA_REG_STEP, step, 4'hf);
        apb_write_reg(`VGA_REG_VDISP, {20'd0, vd}, 4'hf);
        read_expect(`VGA_REG_BPR, {20'd0, bpr}, "bytes per row");
        read_expect(`VGA_REG_STEP, step, "row step");
        read_expect(`VGA_REG_VDISP, {20'd0, vd}, "vdisp");
        wait_bus_reset(100);
        finish_test();

        start_test("interrupts");
        exp_flags = '0;
        for (int i = 0; i < 5; i++) begin
            pulse_event(i);
            exp_flags[i] = 1'b1;
            read_expect(`VGA_REG_INT_FLAGS, {27'd0, exp_flags}, "flags after event");
            check_value("int_out unselected", 0, {31'd0, int_out});
        end
        draw_rand(r);
        sel = r[4:0] | 5'h01;
        apb_write_reg(`VGA_REG_INT_SELECT, {27'd0, sel}, 4'hf);
        @(posedge clk);
        #2;
        check_value("int_out selected", 1, {31'd0, int_out});
        read_expect(`VGA_REG_INT_SELECT, {27'd0, sel}, "int select");
        draw_rand(r);
        clr = r[4:0];
        apb_write_reg(`VGA_REG_INT_FLAGS, {27'd0, clr}, 4'hf);
        exp_flags = exp_flags & ~clr;
        read_expect(`VGA_REG_INT_FLAGS, {27'd0, exp_flags}, "flags after clear");
        check_value("int_out after clear", {31'd0, |(exp_flags & sel)}, {31'd0, int_out});
        apb_write_reg(`VGA_REG_INT_FLAGS, 32'h1f, 4'hf);
        read_expect(`VGA_REG_INT_FLAGS, 32'd0, "flags all cleared");
        check_value("int_out idle", 0, {31'd0, int_out});
        finish_test();

        start_test("row_commands");
        draw_rand(r);
        base = r & 32'hffff_fff0;
        draw_rand(r);
        step = r & 32'h0000_fff0;
        bpr  = r[27:16];
        apb_write_reg(`VGA_REG_VDISP, 32'd3, 4'hf);
        apb_write_reg(`VGA_REG_BUF_ADDR, base, 4'hf);
        apb_write_reg(`VGA_REG_STEP, step, 4'hf);
        apb_write_reg(`VGA_REG_BPR, {20'd0, bpr}, 4'hf);
        apb_write_reg(`VGA_REG_CONTROL, 32'd1, 4'hf);
        collect_rows(4, base, step, bpr);
        expect_no_command(40);
        pulse_event(`VGA_INT_FRAME_DONE);
        collect_rows(4, base, step, bpr);
        expect_no_command(20);
        finish_test();

        start_test("underrun_recovery");
        apb_write_reg(`VGA_REG_INT_FLAGS, 32'h1f, 4'hf);
        axi_busy = 1'b1;
        pulse_event(`VGA_INT_UNDERRUN);
        check_value("axi_halt on underrun", 1, {31'd0, axi_halt});
        read_expect(`VGA_REG_INT_FLAGS, 32'd1 << `VGA_INT_UNDERRUN, "underrun flag");
        // reader still busy, so the halt phase must not end
        expect_no_command(30);
        check_value("axi_halt while busy", 1, {31'd0, axi_halt});
        check_value("rst_bus while busy", 0, {31'd0, rst_bus});
        axi_busy = 1'b0;
        wait_halt_low(100);
        expect_no_command(30);
        pulse_event(`VGA_INT_FRAME_DONE);
        collect_rows(4, base, step, bpr);
        expect_no_command(20);
        finish_test();

        start_test("disable");
        axi_busy = 1'b1;
        apb_write_reg(`VGA_REG_CONTROL, 32'd0, 4'hf);
        check_value("rst_drv", 1, {31'd0, rst_drv});
        check_value("axi_halt", 1, {31'd0, axi_halt});
        check_value("rst_bus while busy", 0, {31'd0, rst_bus});
        read_expect(`VGA_REG_STATUS, 32'd1 << 17, "status busy");
        axi_busy = 1'b0;
        wait_bus_reset(100);
        apb_write_reg(`VGA_REG_INT_FLAGS, 32'h1f, 4'hf);
        apb_write_reg(`VGA_REG_CONTROL, 32'd1, 4'hf);
        pulse_event(`VGA_INT_PX_RST);
        read_expect(`VGA_REG_CONTROL, 32'd0, "enable after px_rst");
        read_expect(`VGA_REG_INT_FLAGS, 32'd1 << `VGA_INT_PX_RST, "px_rst flag");
        finish_test();

        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
logic/vga_regs_pkg.sv
logic/vga_csr_file.sv
logic/vga_irq_ctrl.sv
logic/vga_frame_fsm.sv
logic/vga_row_cmd_gen.sv
logic/vga_regs_top.sv
tests/tb_vga_regs.sv
